// ==== flist.f ====
soc_config_pkg.sv
mem_bus_if.sv
bus_decoder.sv
scratch_ram.sv
machine_timer.sv
soc_bus.sv
tb_soc_bus.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_soc_bus -f flist.f
	./obj_dir/Vtb_soc_bus | tee sim.log
	grep -q -F '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_soc_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_soc_bus;

  localparam int RAM_DEPTH = 256;
  localparam int CYCLE_LIMIT = 2000;

  localparam logic [31:0] MTIME_LO_ADDR = 32'h0200_0000;
  localparam logic [31:0] MTIMECMP_LO_ADDR = 32'h0200_0008;
  localparam logic [31:0] MTIMECMP_HI_ADDR = 32'h0200_000c;

  logic clock;
  logic reset;
  logic memory_valid;
  logic [31:0] memory_addr;
  logic [31:0] memory_wdata;
  logic [3:0] memory_wstrb;
  logic [31:0] memory_rdata;
  logic memory_error;
  logic memory_ready;
  logic timer_irq;

  logic [31:0] ram_model [RAM_DEPTH];
  int errors;
  int tests_run;
  int tests_failed;
  int cycle_count = 0;

  soc_bus #(
    .RAM_DEPTH (RAM_DEPTH)
  ) i_soc_bus (
    .clock (clock),
    .reset (reset),
    .memory_valid (memory_valid),
    .memory_addr (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_error (memory_error),
    .memory_ready (memory_ready),
    .timer_irq (timer_irq)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // every strobe gets its ready in the next cycle, and ready never comes unasked
  assert property (@(posedge clock) disable iff (!reset) memory_valid |=> memory_ready)
    else begin
      $display("FAIL %0t memory_ready got %b expected 1", $time, $sampled(memory_ready));
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) memory_ready |-> $past(memory_valid))
    else begin
      $display("FAIL %0t memory_ready got 1 expected 0 (no request pending)", $time);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) memory_error |-> memory_ready)
    else begin
      $display("FAIL %0t memory_error got 1 expected 0 (ready low)", $time);
      errors++;
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected)
      else begin
        $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
        errors++;
      end
  endtask

  function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strobe);
    logic [31:0] mask;
    mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // one strobe on the falling edge, then wait for the response
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic error);
    @(negedge clock);
    memory_valid = 1'b1;
    memory_addr = addr;
    memory_wdata = wdata;
    memory_wstrb = wstrb;
    @(negedge clock);
    memory_valid = 1'b0;
    memory_wstrb = 4'b0000;
    while (!memory_ready) begin
      @(negedge clock);
    end
    rdata = memory_rdata;
    error = memory_error;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strobe, output logic error);
    logic [31:0] rdata;
    bus_access(addr, data, strobe, rdata, error);
    check_value("memory_rdata", rdata, 32'h0);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic error);
    bus_access(addr, 32'h0, 4'b0000, data, error);
  endtask

  task automatic ram_round_trip();
    int indices [32];
    logic [31:0] data;
    logic error;
    for (int i = 0; i < 32; i++) begin
      indices[i] = int'($urandom_range(RAM_DEPTH - 1, 0));
      data = $urandom;
      bus_write(32'(indices[i] * 4), data, 4'b1111, error);
      check_value("memory_error", 32'(error), 32'h0);
      ram_model[indices[i]] = data;
    end
    for (int i = 0; i < 32; i++) begin
      bus_read(32'(indices[i] * 4), data, error);
      check_value("memory_error", 32'(error), 32'h0);
      check_value("memory_rdata", data, ram_model[indices[i]]);
    end
  endtask

  task automatic byte_strobes();
    logic [3:0] strobes [3] = '{4'b0001, 4'b0100, 4'b1000};
    int index;
    logic [31:0] addr;
    logic [31:0] data;
    logic error;
    index = int'($urandom_range(RAM_DEPTH - 1, 0));
    addr = 32'(index * 4);
    data = $urandom;
    bus_write(addr, data, 4'b1111, error);
    ram_model[index] = data;
    for (int i = 0; i < 3; i++) begin
      data = $urandom;
      bus_write(addr, data, strobes[i], error);
      ram_model[index] = apply_strobe(ram_model[index], data, strobes[i]);
      bus_read(addr, data, error);
      check_value("memory_rdata", data, ram_model[index]);
    end
  endtask

  // the bad addresses would alias onto words 0 and 4 if they leaked into the RAM
  task automatic unmapped_access();
    logic [31:0] bad_addrs [3] = '{32'(RAM_DEPTH * 4), 32'h0100_0000, 32'h0200_0010};
    logic [31:0] data;
    logic error;
    for (int w = 0; w < 8; w += 4) begin
      data = $urandom;
      bus_write(32'(w * 4), data, 4'b1111, error);
      ram_model[w] = data;
    end
    for (int i = 0; i < 3; i++) begin
      bus_write(bad_addrs[i], $urandom, 4'b1111, error);
      check_value("memory_error", 32'(error), 32'h1);
      bus_read(bad_addrs[i], data, error);
      check_value("memory_error", 32'(error), 32'h1);
      check_value("memory_rdata", data, 32'h0);
    end
    for (int w = 0; w < 8; w += 4) begin
      bus_read(32'(w * 4), data, error);
      check_value("memory_rdata", data, ram_model[w]);
    end
  endtask

  task automatic timer_reads();
    logic [31:0] first;
    logic [31:0] second;
    logic error;
    bus_read(MTIME_LO_ADDR, first, error);
    repeat (10) @(negedge clock);
    bus_read(MTIME_LO_ADDR, second, error);
    assert (second > first)
      else begin
        $display("FAIL %0t mtime_lo got %h expected above %h", $time, second, first);
        errors++;
      end
    bus_read(MTIMECMP_LO_ADDR, first, error);
    check_value("mtimecmp_lo", first, 32'hffff_ffff);
    bus_read(MTIMECMP_HI_ADDR, first, error);
    check_value("mtimecmp_hi", first, 32'hffff_ffff);
  endtask

  task automatic timer_interrupt();
    logic [31:0] now;
    logic error;
    int waited;
    bus_write(MTIMECMP_HI_ADDR, 32'h0, 4'b1111, error);
    bus_read(MTIME_LO_ADDR, now, error);
    bus_write(MTIMECMP_LO_ADDR, now + 32'd50, 4'b1111, error);
    check_value("timer_irq", 32'(timer_irq), 32'h0);
    waited = 0;
    while (!timer_irq && waited < 60) begin
      @(negedge clock);
      waited++;
    end
    assert (timer_irq)
      else begin
        $display("FAIL %0t timer_irq did not rise within 60 cycles", $time);
        errors++;
      end
    bus_write(MTIMECMP_HI_ADDR, 32'hffff_ffff, 4'b1111, error);
    @(negedge clock);
    check_value("timer_irq", 32'(timer_irq), 32'h0);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int mark;
    clock = 1'b0;
    reset = 1'b0;
    memory_valid = 1'b0;
    memory_addr = 32'h0;
    memory_wdata = 32'h0;
    memory_wstrb = 4'b0000;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(11));
    repeat (2) @(negedge clock);
    reset = 1'b1;

    mark = errors;
    @(negedge clock);
    check_value("memory_ready", 32'(memory_ready), 32'h0);
    check_value("timer_irq", 32'(timer_irq), 32'h0);
    report_test("reset_state", mark);

    mark = errors;
    ram_round_trip();
    report_test("ram_round_trip", mark);

    mark = errors;
    byte_strobes();
    report_test("byte_strobes", mark);

    mark = errors;
    unmapped_access();
    report_test("unmapped_access", mark);

    mark = errors;
    timer_reads();
    report_test("timer_reads", mark);

    mark = errors;
    timer_interrupt();
    report_test("timer_interrupt", mark);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== soc_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_bus #(
  parameter int RAM_DEPTH = 256
) (
  input logic clock,
  input logic reset,
  input logic memory_valid,
  input logic [31:0] memory_addr,
  input logic [31:0] memory_wdata,
  input logic [3:0] memory_wstrb,
  output logic [31:0] memory_rdata,
  output logic memory_error,
  output logic memory_ready,
  output logic timer_irq
);

  mem_bus_if ram_bus ();
  mem_bus_if timer_bus ();

  bus_decoder #(
    .RAM_DEPTH (RAM_DEPTH)
  ) i_bus_decoder (
    .clock (clock),
    .reset (reset),
    .valid (memory_valid),
    .addr (memory_addr),
    .wdata (memory_wdata),
    .wstrb (memory_wstrb),
    .rdata (memory_rdata),
    .error (memory_error),
    .ready (memory_ready),
    .ram (ram_bus.requester),
    .timer (timer_bus.requester)
  );

  scratch_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) i_scratch_ram (
    .clock (clock),
    .reset (reset),
    .bus (ram_bus.target)
  );

  machine_timer i_machine_timer (
    .clock (clock),
    .reset (reset),
    .bus (timer_bus.target),
    .timer_irq (timer_irq)
  );

endmodule

`default_nettype wire

// ==== machine_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module machine_timer (
  input logic clock,
  input logic reset,
  mem_bus_if.target bus,
  output logic timer_irq
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [3:0] offset;
  logic write;

  assign offset = bus.addr[3:0];
  assign write = bus.valid && (bus.wstrb != 4'b0000);

  // the counter holds still in a cycle that writes either half of mtime
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime <= '0;
    end else if (write && offset == soc_config_pkg::timer_mtime_lo) begin
      mtime[31:0] <= soc_config_pkg::merge_bytes(mtime[31:0], bus.wdata, bus.wstrb);
    end else if (write && offset == soc_config_pkg::timer_mtime_hi) begin
      mtime[63:32] <= soc_config_pkg::merge_bytes(mtime[63:32], bus.wdata, bus.wstrb);
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // all ones after reset keeps the interrupt low until software sets a compare value
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtimecmp <= '1;
    end else if (write && offset == soc_config_pkg::timer_mtimecmp_lo) begin
      mtimecmp[31:0] <= soc_config_pkg::merge_bytes(mtimecmp[31:0], bus.wdata, bus.wstrb);
    end else if (write && offset == soc_config_pkg::timer_mtimecmp_hi) begin
      mtimecmp[63:32] <= soc_config_pkg::merge_bytes(mtimecmp[63:32], bus.wdata, bus.wstrb);
    end
  end

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      if (write) begin
        bus.rdata <= '0;
      end else begin
        case (offset)
          soc_config_pkg::timer_mtime_lo: bus.rdata <= mtime[31:0];
          soc_config_pkg::timer_mtime_hi: bus.rdata <= mtime[63:32];
          soc_config_pkg::timer_mtimecmp_lo: bus.rdata <= mtimecmp[31:0];
          soc_config_pkg::timer_mtimecmp_hi: bus.rdata <= mtimecmp[63:32];
          default: bus.rdata <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
    end
  end

  // level interrupt, cleared only by moving mtimecmp above mtime
  assign timer_irq = mtime >= mtimecmp;

endmodule

`default_nettype wire

// ==== scratch_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module scratch_ram #(
  parameter int RAM_DEPTH = 256
) (
  input logic clock,
  input logic reset,
  mem_bus_if.target bus
);

  localparam int ADDR_WIDTH = $clog2(RAM_DEPTH);

  logic [31:0] mem [RAM_DEPTH];
  logic [ADDR_WIDTH-1:0] index;
  logic write;

  // byte address bits 1:0 select a byte lane and are not part of the index
  assign index = bus.addr[ADDR_WIDTH+1:2];
  assign write = bus.wstrb != 4'b0000;

  always_ff @(posedge clock) begin
    if (bus.valid && write) begin
      mem[index] <= soc_config_pkg::merge_bytes(mem[index], bus.wdata, bus.wstrb);
    end
  end

  // a write answers with zero data
  always_ff @(posedge clock) begin
    if (bus.valid) begin
      if (write) begin
        bus.rdata <= '0;
      end else begin
        bus.rdata <= mem[index];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.valid;
    end
  end

endmodule

`default_nettype wire

// ==== bus_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_decoder #(
  parameter int RAM_DEPTH = 256
) (
  input logic clock,
  input logic reset,
  input logic valid,
  input logic [31:0] addr,
  input logic [31:0] wdata,
  input logic [3:0] wstrb,
  output logic [31:0] rdata,
  output logic error,
  output logic ready,
  mem_bus_if.requester ram,
  mem_bus_if.requester timer
);

  localparam logic [31:0] RAM_SIZE = 32'(RAM_DEPTH * 4);
  localparam logic [31:0] TIMER_SIZE =
    soc_config_pkg::timer_top_addr - soc_config_pkg::timer_base_addr;

  logic [31:0] ram_offset;
  logic [31:0] timer_offset;
  logic ram_hit;
  logic timer_hit;
  logic [31:0] base_addr;
  logic [31:0] rebased_addr;
  logic unmapped;
  logic error_ready;

  // an address below a base wraps to a large offset, so one compare per region is enough
  assign ram_offset = addr - soc_config_pkg::ram_base_addr;
  assign timer_offset = addr - soc_config_pkg::timer_base_addr;
  assign ram_hit = ram_offset < RAM_SIZE;
  assign timer_hit = timer_offset < TIMER_SIZE;

  // timer region has priority over the RAM region
  always_comb begin
    ram.valid = 1'b0;
    timer.valid = 1'b0;
    base_addr = '0;
    unmapped = 1'b0;
    if (valid) begin
      if (timer_hit) begin
        timer.valid = 1'b1;
        base_addr = soc_config_pkg::timer_base_addr;
      end else if (ram_hit) begin
        ram.valid = 1'b1;
        base_addr = soc_config_pkg::ram_base_addr;
      end else begin
        unmapped = 1'b1;
      end
    end
  end

  assign rebased_addr = addr - base_addr;

  assign ram.addr = rebased_addr;
  assign ram.wdata = wdata;
  assign ram.wstrb = wstrb;

  assign timer.addr = rebased_addr;
  assign timer.wdata = wdata;
  assign timer.wstrb = wstrb;

  // unmapped requests are answered one cycle later, like a target would
  always_ff @(posedge clock) begin
    if (!reset) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= unmapped;
    end
  end

  // only one request is in flight, so at most one source is ready at a time
  always_comb begin
    if (ram.ready) begin
      rdata = ram.rdata;
      error = 1'b0;
      ready = 1'b1;
    end else if (timer.ready) begin
      rdata = timer.rdata;
      error = 1'b0;
      ready = 1'b1;
    end else if (error_ready) begin
      rdata = '0;
      error = 1'b1;
      ready = 1'b1;
    end else begin
      rdata = '0;
      error = 1'b0;
      ready = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== mem_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one target's view of the memory bus
// a nonzero wstrb marks a write and a zero wstrb marks a read
interface mem_bus_if;

  logic valid;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic [31:0] rdata;
  logic ready;

  modport requester (
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input rdata,
    input ready
  );

  modport target (
    input valid,
    input addr,
    input wdata,
    input wstrb,
    output rdata,
    output ready
  );

endinterface

`default_nettype wire

// ==== soc_config_pkg.sv ====
`default_nettype none

package soc_config_pkg;

  // the RAM region top follows from the RAM depth of the top level
  localparam logic [31:0] ram_base_addr = 32'h0000_0000;

  // the timer region runs up to but not including the top address
  localparam logic [31:0] timer_base_addr = 32'h0200_0000;
  localparam logic [31:0] timer_top_addr = 32'h0200_0010;

  // byte offsets of the timer registers inside the timer region
  localparam logic [3:0] timer_mtime_lo = 4'h0;
  localparam logic [3:0] timer_mtime_hi = 4'h4;
  localparam logic [3:0] timer_mtimecmp_lo = 4'h8;
  localparam logic [3:0] timer_mtimecmp_hi = 4'hc;

  // replaces only the bytes of old_word whose strobe bit is set
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strobe);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire
